// File: core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// address of the first instruction fetch
`define CORE_RESET_PC 32'h0000_0000

// fetch queue entries, a power of two of at least 2
`define CORE_FQ_DEPTH 4

// architectural register width
`define CORE_XLEN 32

`endif

// File: rv_isa_pkg.sv
`include "core_cfg.svh"

package rv_isa_pkg;

    // data, pc and instruction words
    typedef logic [`CORE_XLEN-1:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // major opcodes from instruction bits 6:0
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_imm   = 7'b0010011,
        op_auipc = 7'b0010111,
        op_store = 7'b0100011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111,
        op_br    = 7'b1100011,
        op_jalr  = 7'b1100111,
        op_jal   = 7'b1101111,
        op_csr   = 7'b1110011
    } opcode_e;

    // funct3 values of the supported ALU operations
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    // alternate funct7, turns ADD into SUB
    localparam logic [6:0] funct7_sub = 7'b0100000;

endpackage

// File: core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    // running count of retired instructions
    typedef logic [63:0] order_t;

    // queue occupancy, one bit wider than the index so full is representable
    typedef logic [$clog2(`CORE_FQ_DEPTH):0] fq_count_t;

    // instruction fetch sequencing
    typedef enum logic [1:0] {
        idle,
        request,
        wait_resp
    } fetch_state_e;

endpackage

// File: instr_fetch.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module instr_fetch (
    input  logic              clk,
    input  logic              rst_n,
    output rv_isa_pkg::word_t imem_address,
    output logic              imem_read,
    input  rv_isa_pkg::word_t imem_rdata,
    input  logic              imem_resp,
    input  logic              room,
    output logic              push,
    output rv_isa_pkg::word_t push_instr,
    output rv_isa_pkg::word_t push_pc
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    fetch_state_e state;
    fetch_state_e state_next;
    word_t        pc;

    // one request in flight at most, started only with room in the queue
    always_comb begin
        state_next = state;
        case (state)
            idle:      if (room) state_next = request;
            request:   state_next = imem_resp ? idle : wait_resp;
            wait_resp: if (imem_resp) state_next = idle;
            default:   state_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            pc    <= `CORE_RESET_PC;
        end else begin
            state <= state_next;
            // no branches, so the pc only ever steps forward
            if (push) begin
                pc <= pc + word_t'(4);
            end
        end
    end

    assign imem_read    = (state != idle);
    assign imem_address = pc;

    // hand the returned word straight to the queue
    assign push       = imem_read && imem_resp;
    assign push_instr = imem_rdata;
    assign push_pc    = pc;

    // magic memory expects read and address held until it answers
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        imem_read && !imem_resp |=> imem_read && $stable(imem_address));

endmodule

// File: fetch_queue.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  rv_isa_pkg::word_t push_instr,
    input  rv_isa_pkg::word_t push_pc,
    input  logic              pop,
    output logic              empty,
    output logic              room,
    output rv_isa_pkg::word_t head_instr,
    output rv_isa_pkg::word_t head_pc
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int depth = `CORE_FQ_DEPTH;
    localparam int ptr_w = $clog2(depth);

    word_t            instr_mem [depth];
    word_t            pc_mem    [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    fq_count_t        count;
    logic             full;

    always_ff @(posedge clk) begin
        if (push) begin
            instr_mem[wr_ptr] <= push_instr;
            pc_mem[wr_ptr]    <= push_pc;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + ptr_w'(1);
            if (pop) rd_ptr <= rd_ptr + ptr_w'(1);
            case ({push, pop})
                2'b10:   count <= count + fq_count_t'(1);
                2'b01:   count <= count - fq_count_t'(1);
                default: ;
            endcase
        end
    end

    assign empty = (count == '0);
    assign full  = (count == fq_count_t'(depth));
    // keep a slot free for the request that may already be in flight
    assign room  = (count <= fq_count_t'(depth - 2));

    assign head_instr = instr_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::word_t    rs1_data,
    output rv_isa_pkg::word_t    rs2_data,
    input  logic                 we,
    input  rv_isa_pkg::reg_idx_t rd,
    input  rv_isa_pkg::word_t    rd_data
);
    import rv_isa_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 empty,
    input  rv_isa_pkg::word_t    head_instr,
    input  rv_isa_pkg::word_t    head_pc,
    output logic                 pop,
    output logic                 monitor_valid,
    output core_pkg::order_t     monitor_order,
    output rv_isa_pkg::word_t    monitor_inst,
    output rv_isa_pkg::word_t    monitor_pc_rdata,
    output rv_isa_pkg::reg_idx_t monitor_rd_addr,
    output rv_isa_pkg::word_t    monitor_rd_wdata
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic       dec_valid;
    word_t      dec_instr;
    word_t      dec_pc;
    reg_idx_t   dec_rs1;
    reg_idx_t   dec_rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      dec_b;
    logic       stall;
    logic       ex_valid;
    word_t      ex_instr;
    word_t      ex_pc;
    word_t      ex_a;
    word_t      ex_b;
    opcode_e    ex_opcode;
    reg_idx_t   ex_rd;
    logic [2:0] ex_funct3;
    logic [6:0] ex_funct7;
    logic       ex_legal;
    word_t      ex_result;
    logic       rf_we;
    order_t     order_q;
    order_t     last_order;
    logic       seen_commit;

    regfile regs (
        .clk(clk),
        .rst_n(rst_n),
        .rs1(dec_rs1),
        .rs2(dec_rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we(rf_we),
        .rd(ex_rd),
        .rd_data(ex_result)
    );

    // decode: fields, second operand and hazard check
    assign dec_rs1 = dec_instr[19:15];
    assign dec_rs2 = dec_instr[24:20];

    always_comb begin
        case (opcode_e'(dec_instr[6:0]))
            op_reg:  dec_b = rs2_data;
            op_lui:  dec_b = {dec_instr[31:12], 12'b0};
            default: dec_b = {{20{dec_instr[31]}}, dec_instr[31:20]};
        endcase
    end

    // result lands in the regfile at the end of this cycle, so wait one
    assign stall = dec_valid && ex_valid && (ex_rd != '0)
        && (dec_rs1 == ex_rd || dec_rs2 == ex_rd);
    assign pop = !empty && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            ex_valid  <= 1'b0;
        end else if (stall) begin
            // bubble into execute, decode holds
            ex_valid <= 1'b0;
        end else begin
            dec_valid <= pop;
            ex_valid  <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_instr <= head_instr;
            dec_pc    <= head_pc;
        end
        if (!stall) begin
            ex_instr <= dec_instr;
            ex_pc    <= dec_pc;
            ex_a     <= rs1_data;
            ex_b     <= dec_b;
        end
    end

    // execute
    assign ex_opcode = opcode_e'(ex_instr[6:0]);
    assign ex_rd     = ex_instr[11:7];
    assign ex_funct3 = ex_instr[14:12];
    assign ex_funct7 = ex_instr[31:25];

    always_comb begin
        ex_result = '0;
        ex_legal  = 1'b0;
        case (ex_opcode)
            op_lui: begin
                ex_result = ex_b;
                ex_legal  = 1'b1;
            end
            op_imm, op_reg: begin
                // register forms take funct7 zero, or the SUB pattern
                ex_legal = (ex_opcode == op_imm) || (ex_funct7 == '0)
                    || (ex_funct7 == funct7_sub && ex_funct3 == funct3_add_sub);
                case (ex_funct3)
                    funct3_add_sub: begin
                        if (ex_opcode == op_reg && ex_funct7 == funct7_sub) begin
                            ex_result = ex_a - ex_b;
                        end else begin
                            ex_result = ex_a + ex_b;
                        end
                    end
                    funct3_xor: ex_result = ex_a ^ ex_b;
                    funct3_or:  ex_result = ex_a | ex_b;
                    funct3_and: ex_result = ex_a & ex_b;
                    // shifts and compares retire as no-ops
                    default:    ex_legal = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    assign rf_we = ex_valid && ex_legal && (ex_rd != '0);

    // commit record
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            monitor_valid <= 1'b0;
            monitor_order <= '0;
            order_q       <= '0;
            seen_commit   <= 1'b0;
        end else begin
            monitor_valid <= ex_valid;
            if (ex_valid) begin
                monitor_order <= order_q;
                order_q       <= order_q + order_t'(1);
            end
            if (monitor_valid) seen_commit <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            monitor_inst     <= ex_instr;
            monitor_pc_rdata <= ex_pc;
            monitor_rd_addr  <= rf_we ? ex_rd : '0;
            monitor_rd_wdata <= rf_we ? ex_result : '0;
        end
        if (monitor_valid) last_order <= monitor_order;
    end

    a_order_step: assert property (@(posedge clk) disable iff (!rst_n)
        monitor_valid |-> monitor_order == (seen_commit ? last_order + order_t'(1) : '0));

endmodule

// File: core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // magic memory instruction port
    output rv_isa_pkg::word_t    imem_address,
    output logic                 imem_read,
    input  rv_isa_pkg::word_t    imem_rdata,
    input  logic                 imem_resp,

    // commit monitor
    output logic                 monitor_valid,
    output core_pkg::order_t     monitor_order,
    output rv_isa_pkg::word_t    monitor_inst,
    output rv_isa_pkg::word_t    monitor_pc_rdata,
    output rv_isa_pkg::reg_idx_t monitor_rd_addr,
    output rv_isa_pkg::word_t    monitor_rd_wdata
);
    import rv_isa_pkg::*;

    logic  room;
    logic  push;
    logic  empty;
    logic  pop;
    word_t push_instr;
    word_t push_pc;
    word_t head_instr;
    word_t head_pc;

    instr_fetch fetch (
        .clk(clk),
        .rst_n(rst_n),
        .imem_address(imem_address),
        .imem_read(imem_read),
        .imem_rdata(imem_rdata),
        .imem_resp(imem_resp),
        .room(room),
        .push(push),
        .push_instr(push_instr),
        .push_pc(push_pc)
    );

    fetch_queue queue (
        .clk(clk),
        .rst_n(rst_n),
        .push(push),
        .push_instr(push_instr),
        .push_pc(push_pc),
        .pop(pop),
        .empty(empty),
        .room(room),
        .head_instr(head_instr),
        .head_pc(head_pc)
    );

    exec_pipe pipe (
        .clk(clk),
        .rst_n(rst_n),
        .empty(empty),
        .head_instr(head_instr),
        .head_pc(head_pc),
        .pop(pop),
        .monitor_valid(monitor_valid),
        .monitor_order(monitor_order),
        .monitor_inst(monitor_inst),
        .monitor_pc_rdata(monitor_pc_rdata),
        .monitor_rd_addr(monitor_rd_addr),
        .monitor_rd_wdata(monitor_rd_wdata)
    );

endmodule

// File: tb_core.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_core;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int reset_cycles = 5;

    logic     clk;
    logic     rst_n;
    word_t    imem_address;
    logic     imem_read;
    word_t    imem_rdata;
    logic     imem_resp;
    logic     monitor_valid;
    order_t   monitor_order;
    word_t    monitor_inst;
    word_t    monitor_pc_rdata;
    reg_idx_t monitor_rd_addr;
    word_t    monitor_rd_wdata;

    // program table with its expected commit values
    word_t    prog_q[$];
    int       test_q[$];
    reg_idx_t exp_rd_q[$];
    word_t    exp_data_q[$];

    word_t       ref_regs [32];
    logic [31:0] lcg_state = 32'd99563;
    int          mem_wait;
    int          mem_lat;
    int          cycles;
    int          checks;
    int          test_errs [1:6];
    string       test_name [1:6];

    core_top DUT (
        .clk(clk),
        .rst_n(rst_n),
        .imem_address(imem_address),
        .imem_read(imem_read),
        .imem_rdata(imem_rdata),
        .imem_resp(imem_resp),
        .monitor_valid(monitor_valid),
        .monitor_order(monitor_order),
        .monitor_inst(monitor_inst),
        .monitor_pc_rdata(monitor_pc_rdata),
        .monitor_rd_addr(monitor_rd_addr),
        .monitor_rd_wdata(monitor_rd_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick_latency();
        return 1 + int'((lcg_next() >> 16) % 32'd3);
    endfunction

    function automatic word_t enc_i(logic [6:0] op, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'(op_reg)};
    endfunction

    function automatic word_t enc_u(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'(op_lui)};
    endfunction

    // past the end of the table the memory returns a word made from the address
    function automatic word_t fetch_word(word_t addr);
        word_t idx;
        idx = (addr - `CORE_RESET_PC) >> 2;
        if (idx < 32'(prog_q.size())) return prog_q[idx];
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    task automatic add_entry(input int test_id, input word_t instr);
        prog_q.push_back(instr);
        test_q.push_back(test_id);
    endtask

    // reference model straight from the RV32I encoding rules
    task automatic compute_expected();
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      res;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       writes;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        foreach (prog_q[i]) begin
            instr  = prog_q[i];
            f3     = instr[14:12];
            f7     = instr[31:25];
            a      = ref_regs[instr[19:15]];
            b      = {{20{instr[31]}}, instr[31:20]};
            res    = '0;
            writes = 1'b0;
            if (instr[6:0] == 7'(op_lui)) begin
                res    = {instr[31:12], 12'b0};
                writes = 1'b1;
            end else if (instr[6:0] == 7'(op_imm) || instr[6:0] == 7'(op_reg)) begin
                if (instr[6:0] == 7'(op_reg)) b = ref_regs[instr[24:20]];
                writes = (instr[6:0] == 7'(op_imm)) || (f7 == 7'd0)
                    || (f7 == funct7_sub && f3 == funct3_add_sub);
                case (f3)
                    funct3_add_sub: begin
                        if (instr[6:0] == 7'(op_reg) && f7 == funct7_sub) res = a - b;
                        else res = a + b;
                    end
                    funct3_xor: res = a ^ b;
                    funct3_or:  res = a | b;
                    funct3_and: res = a & b;
                    default:    writes = 1'b0;
                endcase
            end
            if (writes && instr[11:7] != 5'd0) begin
                ref_regs[instr[11:7]] = res;
                exp_rd_q.push_back(instr[11:7]);
                exp_data_q.push_back(res);
            end else begin
                exp_rd_q.push_back(5'd0);
                exp_data_q.push_back('0);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual, input int test_id);
        checks++;
        assert (actual === expected) else begin
            $display("** Error: %s expected %0h, got %0h (test %0d)",
                     name, expected, actual, test_id);
            test_errs[test_id]++;
        end
    endtask

    task automatic report_test(input int test_id);
        if (test_errs[test_id] == 0) $display("test %0d %s: ok", test_id, test_name[test_id]);
        else $display("test %0d %s: %0d errors", test_id, test_name[test_id],
                      test_errs[test_id]);
    endtask

    // magic memory answering each request after 1 to 3 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_resp <= 1'b0;
            mem_wait = 0;
        end else if (imem_resp) begin
            imem_resp <= 1'b0;
        end else if (imem_read) begin
            mem_wait++;
            if (mem_wait >= mem_lat) begin
                imem_resp  <= 1'b1;
                imem_rdata <= fetch_word(imem_address);
                mem_wait = 0;
                mem_lat  = pick_latency();
            end
        end
    end

    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles < prog_q.size() * 8 + reset_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the core did not retire the whole program in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        int idx;
        int failed;
        rst_n      <= 1'b0;
        imem_resp  <= 1'b0;
        imem_rdata <= '0;
        checks     = 0;
        mem_lat    = pick_latency();
        for (int t = 1; t <= 6; t++) test_errs[t] = 0;
        test_name[1] = "reset state";
        test_name[2] = "immediate ops and lui";
        test_name[3] = "register ops";
        test_name[4] = "dependent back-to-back";
        test_name[5] = "order, pc and inst";
        test_name[6] = "x0 write and illegal op";

        add_entry(2, enc_i(op_imm, funct3_add_sub, 5'd1, 5'd0, 12'd5));
        add_entry(2, enc_i(op_imm, funct3_add_sub, 5'd2, 5'd0, 12'hffd));
        add_entry(2, enc_u(5'd3, 20'h12345));
        add_entry(2, enc_i(op_imm, funct3_xor, 5'd4, 5'd1, 12'hfff));
        add_entry(2, enc_i(op_imm, funct3_and, 5'd5, 5'd2, 12'h0f0));
        add_entry(2, enc_i(op_imm, funct3_or, 5'd6, 5'd3, 12'h678));
        add_entry(2, enc_i(op_imm, funct3_add_sub, 5'd7, 5'd3, 12'h800));
        add_entry(3, enc_r(7'd0, funct3_add_sub, 5'd8, 5'd1, 5'd2));
        add_entry(3, enc_r(funct7_sub, funct3_add_sub, 5'd9, 5'd3, 5'd1));
        add_entry(3, enc_r(7'd0, funct3_and, 5'd10, 5'd6, 5'd4));
        add_entry(3, enc_r(7'd0, funct3_or, 5'd11, 5'd5, 5'd1));
        add_entry(3, enc_r(7'd0, funct3_xor, 5'd12, 5'd6, 5'd7));
        add_entry(4, enc_i(op_imm, funct3_add_sub, 5'd13, 5'd0, 12'd100));
        add_entry(4, enc_i(op_imm, funct3_add_sub, 5'd13, 5'd13, 12'd23));
        add_entry(4, enc_r(funct7_sub, funct3_add_sub, 5'd14, 5'd13, 5'd1));
        add_entry(4, enc_r(7'd0, funct3_add_sub, 5'd15, 5'd1, 5'd14));
        add_entry(4, enc_r(7'd0, funct3_xor, 5'd15, 5'd15, 5'd13));
        add_entry(6, enc_i(op_imm, funct3_add_sub, 5'd0, 5'd1, 12'd77));
        add_entry(6, enc_r(7'd0, funct3_add_sub, 5'd16, 5'd0, 5'd1));
        // unknown opcode aimed at x5
        add_entry(6, enc_i(7'h7f, 3'd0, 5'd5, 5'd1, 12'h123));
        add_entry(6, enc_i(op_imm, funct3_add_sub, 5'd17, 5'd5, 12'd0));
        add_entry(6, enc_r(7'd0, funct3_or, 5'd18, 5'd5, 5'd0));
        compute_expected();

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // first request must come from the reset pc
        do @(posedge clk); while (imem_read !== 1'b1);
        check_value("monitor_valid", 64'd0, 64'(monitor_valid), 1);
        check_value("imem_address", 64'(`CORE_RESET_PC), 64'(imem_address), 1);
        report_test(1);

        idx = 0;
        while (idx < prog_q.size()) begin
            @(posedge clk);
            if (monitor_valid === 1'b1) begin
                check_value("monitor_order", 64'(idx), monitor_order, 5);
                check_value("monitor_pc_rdata", 64'(`CORE_RESET_PC + 32'(idx) * 32'd4),
                            64'(monitor_pc_rdata), 5);
                check_value("monitor_inst", 64'(prog_q[idx]), 64'(monitor_inst), 5);
                check_value("monitor_rd_addr", 64'(exp_rd_q[idx]), 64'(monitor_rd_addr),
                            test_q[idx]);
                check_value("monitor_rd_wdata", 64'(exp_data_q[idx]), 64'(monitor_rd_wdata),
                            test_q[idx]);
                if (idx == prog_q.size() - 1 || test_q[idx + 1] != test_q[idx]) begin
                    report_test(test_q[idx]);
                end
                idx++;
            end
        end
        report_test(5);

        failed = 0;
        for (int t = 1; t <= 6; t++) begin
            if (test_errs[t] != 0) failed++;
        end
        $display("summary: %0d of 6 tests ok, %0d with errors, %0d checks",
                 6 - failed, failed, checks);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
instr_fetch.sv
fetch_queue.sv
regfile.sv
exec_pipe.sv
core_top.sv
tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
